/* superscalar_fetch_pkg.sv */
package superscalar_fetch_pkg;

    // group size, one fetch group per cycle
    localparam int fetch_width = 4;

    // instruction memory geometry, indexed by address bits 9:2
    localparam int mem_words = 256;

    // predictor uses bits 7:2, BTB uses bits 5:2 for index and 15:6 for tag
    localparam int bp_entries  = 64;
    localparam int btb_entries = 16;

    // instruction buffer size in packets
    localparam int buffer_depth = 8;

    // RV32 major opcodes that steer fetch
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;

    // count of instructions, 0 up to fetch_width
    typedef logic [2:0] count_t;

    // byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // table indices and tags
    typedef logic [7:0] mem_index_t;
    typedef logic [5:0] bp_index_t;
    typedef logic [3:0] btb_index_t;
    typedef logic [9:0] btb_tag_t;

    // two-bit saturating counter, taken when msb set
    typedef logic [1:0] counter_t;

    // buffer pointer wraps naturally, occupancy needs one more bit
    typedef logic [$clog2(buffer_depth)-1:0] buffer_ptr_t;
    typedef logic [$clog2(buffer_depth):0]   occupancy_t;

    // one fetched instruction as stored in the buffer
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  predict_taken;
        addr_t predicted_pc;
        logic  is_jump;
    } fetch_packet_t;

    // branch outcome coming back from the back end
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } resolve_t;

endpackage

/* fetch_instruction_memory.sv */
`timescale 1ns/1ps

module fetch_instruction_memory
    import superscalar_fetch_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         load_valid,
    input  addr_t                        load_addr,
    input  inst_t                        load_inst,
    input  addr_t  [fetch_width-1:0]     pcs,
    output inst_t  [fetch_width-1:0]     insts,
    output logic   [fetch_width-1:0]     miss
);

    // program store, contents only meaningful where loaded is set
    inst_t words [mem_words];
    logic [mem_words-1:0] loaded;

    mem_index_t load_index;
    mem_index_t read_index [fetch_width];

    // word address from byte address
    assign load_index = load_addr[9:2];

    // loaded bits are the only state that needs clearing
    always_ff @(posedge clock) begin
        if (reset) begin
            loaded <= '0;
        end else if (load_valid) begin
            loaded[load_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (load_valid) begin
            words[load_index] <= load_inst;
        end
    end

    // four independent read ports
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            read_index[i] = pcs[i][9:2];
            miss[i] = !loaded[read_index[i]];
            // unloaded slots read as zero so nothing undefined reaches decode
            insts[i] = loaded[read_index[i]] ? words[read_index[i]] : '0;
        end
    end

    // loads come in whole words only
    load_aligned: assert property (
        @(posedge clock) disable iff (reset)
        load_valid |-> (load_addr[1:0] == 2'b00)
    );

endmodule

/* bimodal_predictor.sv */
`timescale 1ns/1ps

module bimodal_predictor
    import superscalar_fetch_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  addr_t  [fetch_width-1:0]     pcs,
    input  resolve_t                     resolve,
    output logic   [fetch_width-1:0]     taken
);

    // one two-bit counter per table slot
    counter_t counters [bp_entries];

    bp_index_t update_index;
    counter_t  update_old;
    counter_t  update_new;

    assign update_index = resolve.pc[7:2];
    assign update_old   = counters[update_index];

    // saturate at 0 and 3
    always_comb begin
        update_new = update_old;
        if (resolve.taken) begin
            if (update_old != 2'b11) begin
                update_new = update_old + 2'b01;
            end
        end else begin
            if (update_old != 2'b00) begin
                update_new = update_old - 2'b01;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // every counter starts weakly not-taken
            for (int i = 0; i < bp_entries; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (resolve.valid) begin
            counters[update_index] <= update_new;
        end
    end

    // msb of the counter is the prediction
    // reads see the pre-update value in the update cycle
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            taken[i] = counters[pcs[i][7:2]][1];
        end
    end

endmodule

/* branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer
    import superscalar_fetch_pkg::*;
(
    input  logic                         clock,
    input  logic                         reset,
    input  addr_t  [fetch_width-1:0]     pcs,
    input  resolve_t                     resolve,
    output logic   [fetch_width-1:0]     hits,
    output addr_t  [fetch_width-1:0]     targets
);

    // direct mapped with one entry per index
    logic [btb_entries-1:0] entry_valid;
    btb_tag_t entry_tag    [btb_entries];
    addr_t    entry_target [btb_entries];

    btb_index_t write_index;
    btb_tag_t   write_tag;
    logic       write_enable;

    btb_index_t read_index [fetch_width];
    btb_tag_t   read_tag   [fetch_width];

    assign write_index  = resolve.pc[5:2];
    assign write_tag    = resolve.pc[15:6];
    // only taken outcomes carry a target worth remembering
    assign write_enable = resolve.valid && resolve.taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (write_enable) begin
            entry_valid[write_index] <= 1'b1;
        end
    end

    // tag and target only count where entry_valid is set
    always_ff @(posedge clock) begin
        if (write_enable) begin
            entry_tag[write_index]    <= write_tag;
            entry_target[write_index] <= resolve.target;
        end
    end

    // lookup for all four slots
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            read_index[i] = pcs[i][5:2];
            read_tag[i]   = pcs[i][15:6];
            hits[i]       = entry_valid[read_index[i]]
                            && (entry_tag[read_index[i]] == read_tag[i]);
            targets[i]    = entry_target[read_index[i]];
        end
    end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import superscalar_fetch_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 restore_valid,
    input  addr_t                                restore_pc,
    input  inst_t          [fetch_width-1:0]     insts,
    input  logic           [fetch_width-1:0]     miss,
    input  logic           [fetch_width-1:0]     taken,
    input  logic           [fetch_width-1:0]     hits,
    input  addr_t          [fetch_width-1:0]     targets,
    input  count_t                               spots,
    output addr_t          [fetch_width-1:0]     pcs,
    output fetch_packet_t  [fetch_width-1:0]     packets,
    output count_t                               valid_count
);

    addr_t pc_reg;
    addr_t base_pc;
    addr_t next_pc;

    // one extra entry gives the fall-through pc past the last slot
    addr_t [fetch_width:0] group_pcs;

    logic [fetch_width-1:0] is_branch;
    logic [fetch_width-1:0] is_jump;
    logic [fetch_width-1:0] redirect;
    logic [fetch_width-1:0] stop;

    count_t     cut;
    logic [1:0] last_slot;

    // restore overrides the held pc for this cycle's group
    assign base_pc = restore_valid ? restore_pc : pc_reg;

    always_comb begin
        for (int i = 0; i <= fetch_width; i++) begin
            group_pcs[i] = base_pc + addr_t'(4 * i);
        end
    end

    assign pcs = group_pcs[fetch_width-1:0];

    // light predecode on the opcode field
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            is_branch[i] = (insts[i][6:0] == opcode_branch);
            is_jump[i]   = (insts[i][6:0] == opcode_jal)
                           || (insts[i][6:0] == opcode_jalr);
            // predictor taken bit only counts on a real branch
            redirect[i]  = (is_branch[i] && taken[i]) || is_jump[i];
        end
    end

    // a slot stops the group if it missed or the slot before it redirects
    assign stop = miss | (redirect << 1);

    // lowest set bit of stop is the cut and none set means a full group
    always_comb begin
        cut = count_t'(fetch_width);
        for (int i = fetch_width - 1; i >= 0; i--) begin
            if (stop[i]) begin
                cut = count_t'(i);
            end
        end
    end

    // buffer space limits the group further
    assign valid_count = (cut <= spots) ? cut : spots;

    // build all four packets and let the buffer take the first valid_count
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            packets[i].inst          = insts[i];
            packets[i].pc            = group_pcs[i];
            packets[i].predict_taken = redirect[i];
            packets[i].predicted_pc  = hits[i] ? targets[i] : group_pcs[i+1];
            packets[i].is_jump       = is_jump[i];
        end
    end

    // slot index of the last kept instruction, only used when valid_count is nonzero
    assign last_slot = valid_count[1:0] - 2'd1;

    // follow the prediction of the last kept slot or fall through
    always_comb begin
        if ((valid_count != '0) && redirect[last_slot]) begin
            next_pc = packets[last_slot].predicted_pc;
        end else begin
            next_pc = group_pcs[valid_count];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= '0;
        end else begin
            pc_reg <= next_pc;
        end
    end

    // never hand the buffer more than it offered
    fits_spots: assert property (
        @(posedge clock) disable iff (reset)
        valid_count <= spots
    );

endmodule

/* instruction_buffer.sv */
`timescale 1ns/1ps

module instruction_buffer
    import superscalar_fetch_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  fetch_packet_t  [fetch_width-1:0]     packets,
    input  count_t                               valid_count,
    input  count_t                               pop_count,
    output fetch_packet_t  [fetch_width-1:0]     head,
    output logic           [3:0]                 occupancy,
    output count_t                               spots
);

    // circular storage, pointers wrap since depth is a power of two
    fetch_packet_t entries [buffer_depth];

    buffer_ptr_t head_ptr;
    buffer_ptr_t tail_ptr;
    occupancy_t  count_reg;
    occupancy_t  free_entries;
    count_t      pop_actual;

    assign occupancy    = count_reg;
    assign free_entries = occupancy_t'(buffer_depth) - count_reg;

    // spots offered to fetch, capped at a full group
    assign spots = (free_entries >= occupancy_t'(fetch_width))
                   ? count_t'(fetch_width) : count_t'(free_entries);

    // cannot pop more than is stored
    assign pop_actual = (occupancy_t'(pop_count) <= count_reg)
                        ? pop_count : count_t'(count_reg);

    // payload writes at the tail, no reset needed
    always_ff @(posedge clock) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (count_t'(i) < valid_count) begin
                entries[tail_ptr + buffer_ptr_t'(i)] <= packets[i];
            end
        end
    end

    // push and pop in the same cycle are fine, they touch disjoint entries
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count_reg <= '0;
        end else begin
            head_ptr  <= head_ptr + buffer_ptr_t'(pop_actual);
            tail_ptr  <= tail_ptr + buffer_ptr_t'(valid_count);
            count_reg <= count_reg + occupancy_t'(valid_count)
                         - occupancy_t'(pop_actual);
        end
    end

    // oldest four entries, slots past occupancy are stale
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            head[i] = entries[head_ptr + buffer_ptr_t'(i)];
        end
    end

    occupancy_bound: assert property (
        @(posedge clock) disable iff (reset)
        count_reg <= occupancy_t'(buffer_depth)
    );

    // fetch must respect the space offered last cycle
    push_fits: assert property (
        @(posedge clock) disable iff (reset)
        occupancy_t'(valid_count) <= free_entries
    );

endmodule

/* superscalar_fetch.sv */
`timescale 1ns/1ps

module superscalar_fetch
    import superscalar_fetch_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 load_valid,
    input  addr_t                                load_addr,
    input  inst_t                                load_inst,
    input  logic                                 restore_valid,
    input  addr_t                                restore_pc,
    input  resolve_t                             resolve,
    input  count_t                               pop_count,
    output fetch_packet_t  [fetch_width-1:0]     head,
    output logic           [3:0]                 occupancy
);

    // fetch group pcs fan out to all three lookups
    addr_t         [fetch_width-1:0] pcs;
    inst_t         [fetch_width-1:0] insts;
    logic          [fetch_width-1:0] miss;
    logic          [fetch_width-1:0] taken;
    logic          [fetch_width-1:0] hits;
    addr_t         [fetch_width-1:0] targets;

    // fetch to buffer handshake
    fetch_packet_t [fetch_width-1:0] packets;
    count_t                          valid_count;
    count_t                          spots;

    fetch_instruction_memory u_memory (
        .clock      (clock),
        .reset      (reset),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_inst  (load_inst),
        .pcs        (pcs),
        .insts      (insts),
        .miss       (miss)
    );

    bimodal_predictor u_predictor (
        .clock   (clock),
        .reset   (reset),
        .pcs     (pcs),
        .resolve (resolve),
        .taken   (taken)
    );

    branch_target_buffer u_btb (
        .clock   (clock),
        .reset   (reset),
        .pcs     (pcs),
        .resolve (resolve),
        .hits    (hits),
        .targets (targets)
    );

    fetch_stage u_fetch (
        .clock         (clock),
        .reset         (reset),
        .restore_valid (restore_valid),
        .restore_pc    (restore_pc),
        .insts         (insts),
        .miss          (miss),
        .taken         (taken),
        .hits          (hits),
        .targets       (targets),
        .spots         (spots),
        .pcs           (pcs),
        .packets       (packets),
        .valid_count   (valid_count)
    );

    instruction_buffer u_buffer (
        .clock       (clock),
        .reset       (reset),
        .packets     (packets),
        .valid_count (valid_count),
        .pop_count   (pop_count),
        .head        (head),
        .occupancy   (occupancy),
        .spots       (spots)
    );

endmodule

/* superscalar_fetch_tb.sv */
`timescale 1ns/1ps

module superscalar_fetch_tb
    import superscalar_fetch_pkg::*;
();

    localparam int clock_period    = 20;
    localparam int reset_cycles    = 10;
    localparam int cycles_per_line = 50;

    logic                            clock;
    logic                            reset;
    logic                            load_valid;
    addr_t                           load_addr;
    inst_t                           load_inst;
    logic                            restore_valid;
    addr_t                           restore_pc;
    resolve_t                        resolve;
    count_t                          pop_count;
    fetch_packet_t [fetch_width-1:0] head;
    logic          [3:0]             occupancy;

    int error_count;
    int check_count;
    int trace_lines;

    // reference copy of the branch counters, trained by the trace's resolves
    counter_t model_counters [bp_entries];

    superscalar_fetch u_superscalar_fetch (
        .clock         (clock),
        .reset         (reset),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_inst     (load_inst),
        .restore_valid (restore_valid),
        .restore_pc    (restore_pc),
        .resolve       (resolve),
        .pop_count     (pop_count),
        .head          (head),
        .occupancy     (occupancy)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // every command strobe lasts one cycle
    task automatic clear_inputs();
        load_valid    = 1'b0;
        load_addr     = '0;
        load_inst     = '0;
        restore_valid = 1'b0;
        restore_pc    = '0;
        resolve       = '0;
        pop_count     = '0;
    endtask

    // let the edge take the command and release strobes 1 ns later
    task automatic advance_cycle();
        @(posedge clock);
        #1;
        clear_inputs();
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1)) begin
            ch = $fgetc(fd);
        end
    endtask

    // newline count sizes the watchdog
    task automatic count_trace_lines();
        int fd;
        int ch;
        int lines;
        lines = 1;
        fd = $fopen("superscalar_fetch_trace.txt", "r");
        if (fd != 0) begin
            ch = $fgetc(fd);
            while (ch != -1) begin
                if (ch == 10) begin
                    lines++;
                end
                ch = $fgetc(fd);
            end
            $fclose(fd);
        end
        trace_lines = lines;
    endtask

    // saturating two-bit update, up on taken and down on not-taken
    task automatic train_model(input addr_t pc, input logic was_taken);
        bp_index_t index;
        index = pc[7:2];
        if (was_taken) begin
            if (model_counters[index] != 2'b11) begin
                model_counters[index] = model_counters[index] + 2'b01;
            end
        end else if (model_counters[index] != 2'b00) begin
            model_counters[index] = model_counters[index] - 2'b01;
        end
    endtask

    task automatic require_fields(input int got, input int want, input logic [7:0] cmd);
        if (got != want) begin
            $display("trace command %c carries %0d fields where %0d were needed",
                     cmd, got, want);
            error_count++;
        end
    endtask

    // one head slot against the expected packet
    task automatic compare_head_slot(input logic [1:0] slot, input addr_t pc,
                                     input inst_t inst, input addr_t predicted_pc);
        logic expect_jump;
        logic expect_branch;
        logic expect_taken;
        // jal and jalr always redirect, a branch only when its counter msb is set
        expect_jump   = (inst[6:0] == opcode_jal) || (inst[6:0] == opcode_jalr);
        expect_branch = (inst[6:0] == opcode_branch);
        expect_taken  = expect_jump
                        || (expect_branch && model_counters[pc[7:2]][1]);
        check_count++;
        if (head[slot].pc !== pc) begin
            $display("** Error head[%0d].pc expected %h got %h", slot, pc, head[slot].pc);
            error_count++;
        end
        check_count++;
        if (head[slot].inst !== inst) begin
            $display("** Error head[%0d].inst expected %h got %h",
                     slot, inst, head[slot].inst);
            error_count++;
        end
        check_count++;
        if (head[slot].predicted_pc !== predicted_pc) begin
            $display("** Error head[%0d].predicted_pc expected %h got %h",
                     slot, predicted_pc, head[slot].predicted_pc);
            error_count++;
        end
        check_count++;
        if (head[slot].is_jump !== expect_jump) begin
            $display("** Error head[%0d].is_jump expected %h got %h",
                     slot, expect_jump, head[slot].is_jump);
            error_count++;
        end
        check_count++;
        if (head[slot].predict_taken !== expect_taken) begin
            $display("** Error head[%0d].predict_taken expected %h got %h",
                     slot, expect_taken, head[slot].predict_taken);
            error_count++;
        end
    endtask

    task automatic verify_occupancy(input logic [3:0] expected);
        check_count++;
        if (occupancy !== expected) begin
            $display("** Error occupancy expected %h got %h", expected, occupancy);
            error_count++;
        end
    endtask

    // watchdog allows 50 cycles per trace line plus reset
    initial begin
        wait (trace_lines > 0);
        #((trace_lines * cycles_per_line + reset_cycles) * clock_period);
        $display("watchdog expired before the trace finished, %0d errors so far",
                 error_count);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int         fd;
        int         code;
        logic [7:0] cmd;
        addr_t      arg_addr;
        inst_t      arg_inst;
        addr_t      arg_target;
        logic       arg_taken;
        count_t     arg_count;
        logic [1:0] arg_slot;
        logic [3:0] arg_occ;
        error_count = 0;
        check_count = 0;
        trace_lines = 0;
        // counters come out of reset weakly not-taken
        for (int i = 0; i < bp_entries; i++) begin
            model_counters[i] = 2'b01;
        end
        reset = 1'b1;
        clear_inputs();
        count_trace_lines();
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
        fd = $fopen("superscalar_fetch_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file, no commands were run");
            error_count++;
        end else begin
            code = $fscanf(fd, " %c", cmd);
            while (code == 1) begin
                case (cmd)
                    "#": skip_line(fd);
                    "L": begin
                        code = $fscanf(fd, "%h %h", arg_addr, arg_inst);
                        require_fields(code, 2, cmd);
                        load_valid = 1'b1;
                        load_addr  = arg_addr;
                        load_inst  = arg_inst;
                        advance_cycle();
                    end
                    "R": begin
                        code = $fscanf(fd, "%h", arg_addr);
                        require_fields(code, 1, cmd);
                        restore_valid = 1'b1;
                        restore_pc    = arg_addr;
                        advance_cycle();
                    end
                    "U": begin
                        code = $fscanf(fd, "%h %d %h", arg_addr, arg_taken, arg_target);
                        require_fields(code, 3, cmd);
                        resolve.valid  = 1'b1;
                        resolve.pc     = arg_addr;
                        resolve.taken  = arg_taken;
                        resolve.target = arg_target;
                        train_model(arg_addr, arg_taken);
                        advance_cycle();
                    end
                    "P": begin
                        code = $fscanf(fd, "%d", arg_count);
                        require_fields(code, 1, cmd);
                        pop_count = arg_count;
                        advance_cycle();
                    end
                    // expectations take no cycle and look at the current head
                    "E": begin
                        code = $fscanf(fd, "%d %h %h %h",
                                       arg_slot, arg_addr, arg_inst, arg_target);
                        require_fields(code, 4, cmd);
                        compare_head_slot(arg_slot, arg_addr, arg_inst, arg_target);
                    end
                    "C": begin
                        code = $fscanf(fd, "%d", arg_occ);
                        require_fields(code, 1, cmd);
                        verify_occupancy(arg_occ);
                    end
                    default: begin
                        $display("unknown trace command %c, line skipped", cmd);
                        error_count++;
                        skip_line(fd);
                    end
                endcase
                code = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end
        $display("summary: %0d checks run, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* superscalar_fetch_trace.txt */
# L addr inst | R pc | U pc taken target | P pops | C occupancy, one cycle per L R U P
# E slot pc inst predicted_pc checks head at once; addr, inst, pc and target in hex
L 0000000C 00400013
L 00000008 00300013
L 00000004 00200013
L 00000014 02C0006F
L 00000040 00600013
L 00000044 02000E63
L 00000048 00700013
L 0000004C 00800013
L 00000080 00900013
L 00000084 00A00013
L 00000088 00B00013
L 0000008C 00C00013
U 00000014 1 00000040
U 00000044 1 00000080
U 00000044 1 00000080
L 00000000 00100013
P 0
C 4
E 0 00000000 00100013 00000004
E 3 0000000C 00400013 00000010
P 0
C 4
L 00000010 00500013
P 0
P 0
P 0
C 8
P 4
C 4
E 0 00000010 00500013 00000014
E 1 00000014 02C0006F 00000040
E 2 00000040 00600013 00000044
E 3 00000044 02000E63 00000080
P 4
E 0 00000080 00900013 00000084
E 3 0000008C 00C00013 00000090
U 00000044 0 00000000
U 00000044 0 00000000
R 00000040
C 8
P 4
E 0 00000040 00600013 00000044
E 1 00000044 02000E63 00000080
E 2 00000048 00700013 0000004C
E 3 0000004C 00800013 00000050
P 4
C 0

/* superscalar_fetch.f */
superscalar_fetch_pkg.sv
fetch_instruction_memory.sv
bimodal_predictor.sv
branch_target_buffer.sv
fetch_stage.sv
instruction_buffer.sv
superscalar_fetch.sv
superscalar_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the fetch testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module superscalar_fetch_tb -f superscalar_fetch.f \
    && ./obj_dir/Vsuperscalar_fetch_tb | tee /dev/stderr | grep -q '^>>> PASS$' \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
